// ==== hw/z80_bus_pkg.sv ====
/*
  z80 bus subsystem shared definitions
  bus widths, trace record sizing and the access kind tag that
  travels on the wishbone address tag
*/
package z80_bus_pkg;

  localparam int addr_w = 16; // z80 address bus
  localparam int data_w = 8;  // z80 data bus

  // most opcode bytes a single trace record can hold
  localparam int trace_bytes = 4;
  localparam int trace_cnt_w = $clog2(trace_bytes + 1); // counts 0 to trace_bytes

  // the core reports machine cycle and t-state one-hot
  localparam int mcycle_w = 7;
  localparam int tstate_w = 7;

  // kind of access, driven on wb_tga for the whole wishbone cycle
  typedef enum logic [2:0] {
    kind_idle    = 3'd0, // no cycle in progress
    kind_mem_rd  = 3'd1,
    kind_mem_wr  = 3'd2,
    kind_io_rd   = 3'd3,
    kind_io_wr   = 3'd4,
    kind_int_ack = 3'd5  // m1 with iorq, the vector read
  } cycle_kind_t;

endpackage

// ==== hw/z80_bus_if.sv ====
/*
  z80 strobed access bus
  carries the registered strobes, address and write data from the
  strobe generator and the completed read back from the bridge
*/
`timescale 1ns/1ps

interface z80_bus_if;

  logic                          mreq;    // memory select
  logic                          iorq;    // io select, also used for interrupt ack
  logic                          rd;      // read strobe
  logic                          wr;      // write strobe
  logic                          m1;      // opcode fetch or interrupt ack cycle
  logic [z80_bus_pkg::addr_w-1:0] addr;
  logic [z80_bus_pkg::data_w-1:0] dout;    // write data from the core
  logic [z80_bus_pkg::data_w-1:0] rd_data; // byte returned by the last read
  logic                          rd_done; // one clock pulse when rd_data is fresh

  // strobe generator side
  modport strobe (output mreq, iorq, rd, wr, m1, addr, dout);

  // wishbone bridge side
  modport bridge (input mreq, iorq, rd, wr, m1, addr, dout, output rd_data, rd_done);

  // opcode tracer only watches fetches and completions
  modport tracer (input m1, mreq, addr, rd_data, rd_done);

endinterface

// ==== hw/z80_strobe_gen.sv ====
/*
  z80 bus strobe generator
  decodes machine cycle and t-state into mreq, iorq, rd and wr and
  registers them so the strobes come out glitch free, one clock
  behind the t-state that asked for them
*/
`timescale 1ns/1ps

module z80_strobe_gen (
  input  logic                              cpu_bus,
  input  logic                              arst_n,
  input  logic [z80_bus_pkg::mcycle_w-1:0]  mcycle,   // one-hot, bit 0 is m1
  input  logic [z80_bus_pkg::tstate_w-1:0]  tstate,   // one-hot, bit 1 is t1
  input  logic                              write,    // current machine cycle writes
  input  logic                              iorq_req, // current machine cycle is io
  input  logic                              no_read,  // machine cycle has no bus read
  input  logic                              intcycle, // m1 is an interrupt ack
  input  logic                              m1_in,
  input  logic [z80_bus_pkg::addr_w-1:0]    addr_in,
  input  logic [z80_bus_pkg::data_w-1:0]    dout_in,
  z80_bus_if.strobe                         bus
);

  logic nxt_mreq;
  logic nxt_iorq;
  logic nxt_rd;
  logic nxt_wr;
  logic t12;      // core is in t1 or t2

  assign t12 = tstate[1] | tstate[2];

  always_comb
  begin
    nxt_mreq = 1'b0;
    nxt_iorq = 1'b0;
    nxt_rd   = 1'b0;
    nxt_wr   = 1'b0;
    if (mcycle[0])
    begin
      // opcode fetch reads memory, an interrupt ack selects io without rd
      if (t12)
      begin
        nxt_rd   = ~intcycle;
        nxt_mreq = ~intcycle;
        nxt_iorq = intcycle;
      end
    end
    else
    begin
      if (t12 && !no_read && !write) // operand or io read
      begin
        nxt_rd   = 1'b1;
        nxt_iorq = iorq_req;
        nxt_mreq = ~iorq_req;
      end
      if (tstate[2] && write)         // standard timing puts wr in t2 only
      begin
        nxt_wr   = 1'b1;
        nxt_iorq = iorq_req;
        nxt_mreq = ~iorq_req;
      end
    end
  end

  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bus.mreq <= 1'b0;
      bus.iorq <= 1'b0;
      bus.rd   <= 1'b0;
      bus.wr   <= 1'b0;
      bus.m1   <= 1'b0;
    end
    else
    begin
      bus.mreq <= nxt_mreq;
      bus.iorq <= nxt_iorq;
      bus.rd   <= nxt_rd;
      bus.wr   <= nxt_wr;
      bus.m1   <= m1_in; // kept in step with the strobes
    end
  end

  // address and data follow the strobes through the same register stage
  always_ff @(posedge cpu_bus)
  begin
    bus.addr <= addr_in;
    bus.dout <= dout_in;
  end

endmodule

// ==== hw/wb_bus_bridge.sv ====
/*
  z80 to wishbone classic bridge
  turns each strobed access into exactly one wishbone cycle, holds
  the core with wait_n until ack and keeps the read byte for it
*/
`timescale 1ns/1ps

module wb_bus_bridge (
  input  logic                             cpu_bus,
  input  logic                             arst_n,
  z80_bus_if.bridge                        bus,
  input  logic [z80_bus_pkg::data_w-1:0]   wb_dat_i,
  input  logic                             wb_ack,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic                             wb_we,
  output logic [z80_bus_pkg::addr_w-1:0]   wb_adr,
  output logic [z80_bus_pkg::data_w-1:0]   wb_dat_o,
  output z80_bus_pkg::cycle_kind_t         wb_tga,
  output logic                             wait_n,
  output logic [z80_bus_pkg::data_w-1:0]   di
);

  logic                            sel;       // mreq or iorq asserted
  logic                            dir;       // rd, wr or interrupt ack present
  logic                            req;       // access not yet turned into a cycle
  logic                            iack_q;    // this access already got its cycle
  logic                            rd_done_q;
  logic [z80_bus_pkg::data_w-1:0]  rd_data_q;
  logic                            cyc_end;   // ack seen on the running cycle
  z80_bus_pkg::cycle_kind_t        kind;

  assign sel     = bus.mreq | bus.iorq;
  assign dir     = bus.rd | bus.wr | (bus.m1 & bus.iorq); // int ack has no rd
  assign req     = sel & dir & ~iack_q;
  assign cyc_end = wb_cyc & wb_ack;

  // classify the access from the strobes, interrupt ack wins over io read
  always_comb
  begin
    if (bus.iorq && bus.m1)
      kind = z80_bus_pkg::kind_int_ack;
    else if (bus.iorq)
      kind = bus.wr ? z80_bus_pkg::kind_io_wr : z80_bus_pkg::kind_io_rd;
    else if (bus.mreq)
      kind = bus.wr ? z80_bus_pkg::kind_mem_wr : z80_bus_pkg::kind_mem_rd;
    else
      kind = z80_bus_pkg::kind_idle;
  end

  // request latch, cleared only once both selects have dropped
  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
      iack_q <= 1'b0;
    else if (!sel)
      iack_q <= 1'b0;
    else if (req)
      iack_q <= 1'b1;
  end

  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_cyc    <= 1'b0;
      wb_stb    <= 1'b0;
      wb_we     <= 1'b0;
      wb_tga    <= z80_bus_pkg::kind_idle;
      rd_done_q <= 1'b0;
    end
    else
    begin
      rd_done_q <= 1'b0;  // single clock pulse
      if (req)
      begin
        wb_cyc <= 1'b1;   // cyc and stb rise together
        wb_stb <= 1'b1;
        wb_we  <= bus.wr;
        wb_tga <= kind;
      end
      else if (cyc_end)
      begin
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
        wb_we     <= 1'b0;
        wb_tga    <= z80_bus_pkg::kind_idle;
        rd_done_q <= ~wb_we; // reads and interrupt ack return data
      end
    end
  end

  // address and write data are captured at the start and held until ack
  always_ff @(posedge cpu_bus)
  begin
    if (req)
    begin
      wb_adr   <= bus.addr;
      wb_dat_o <= bus.dout;
    end
    if (cyc_end && !wb_we)
      rd_data_q <= wb_dat_i;
  end

  // low from the request through the ack clock, so di is valid when it rises
  assign wait_n      = ~(req | wb_cyc);
  assign di          = rd_data_q;
  assign bus.rd_data = rd_data_q;
  assign bus.rd_done = rd_done_q;

endmodule

// ==== hw/opcode_tracer.sv ====
/*
  opcode tracer
  gathers the bytes read for each instruction and publishes one
  record per instruction when the next opcode fetch completes
*/
`timescale 1ns/1ps

module opcode_tracer (
  input  logic                                              cpu_bus,
  input  logic                                              arst_n,
  z80_bus_if.tracer                                         bus,
  output logic                                              trace_valid,
  output logic [z80_bus_pkg::trace_bytes*z80_bus_pkg::data_w-1:0] trace_opcode,
  output logic [z80_bus_pkg::trace_cnt_w-1:0]               trace_count,
  output logic [z80_bus_pkg::addr_w-1:0]                    trace_addr
);

  logic [z80_bus_pkg::data_w-1:0]      gather_q [z80_bus_pkg::trace_bytes]; // byte 0 is the opcode
  logic [z80_bus_pkg::trace_cnt_w-1:0] count_q;   // bytes gathered so far
  logic [z80_bus_pkg::addr_w-1:0]      start_q;   // fetch address of the current instruction
  logic                                started_q; // at least one fetch seen since reset
  logic                                mem_done;  // a memory read just completed
  logic                                fetch_done;

  // interrupt ack completes with iorq and no mreq, so it is never counted
  assign mem_done   = bus.rd_done & bus.mreq;
  assign fetch_done = mem_done & bus.m1;

  always_ff @(posedge cpu_bus or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count_q     <= '0;
      started_q   <= 1'b0;
      trace_valid <= 1'b0;
    end
    else
    begin
      trace_valid <= 1'b0;
      if (fetch_done)
      begin
        trace_valid <= started_q; // first fetch after reset has nothing to report
        started_q   <= 1'b1;
        count_q     <= z80_bus_pkg::trace_cnt_w'(1);
      end
      else if (mem_done && count_q != z80_bus_pkg::trace_cnt_w'(z80_bus_pkg::trace_bytes))
        count_q <= count_q + 1'b1; // saturates when the buffer is full
    end
  end

  // gather buffer and the published record
  always_ff @(posedge cpu_bus)
  begin
    if (fetch_done)
    begin
      // publish the previous instruction with its first byte in the top byte
      for (int i = 0; i < z80_bus_pkg::trace_bytes; i++)
        trace_opcode[(z80_bus_pkg::trace_bytes-1-i)*z80_bus_pkg::data_w +: z80_bus_pkg::data_w]
          <= gather_q[i];
      trace_count <= count_q;
      trace_addr  <= start_q;
      start_q     <= bus.addr;
      gather_q[0] <= bus.rd_data;
      for (int i = 1; i < z80_bus_pkg::trace_bytes; i++)
        gather_q[i] <= '0; // short instructions leave zeros behind
    end
    else if (mem_done)
    begin
      for (int i = 0; i < z80_bus_pkg::trace_bytes; i++)
        if (count_q == z80_bus_pkg::trace_cnt_w'(i))
          gather_q[i] <= bus.rd_data;
    end
  end

endmodule

// ==== hw/z80_bus_sys.sv ====
/*
  z80 bus subsystem top level
  strobe generator, wishbone bridge and opcode tracer joined by
  one strobed access bus
*/
`timescale 1ns/1ps

module z80_bus_sys (
  input  logic                                              cpu_bus,
  input  logic                                              arst_n,
  // core side
  input  logic [z80_bus_pkg::mcycle_w-1:0]                  mcycle,
  input  logic [z80_bus_pkg::tstate_w-1:0]                  tstate,
  input  logic                                              write,
  input  logic                                              iorq_req,
  input  logic                                              no_read,
  input  logic                                              intcycle,
  input  logic                                              m1_in,
  input  logic [z80_bus_pkg::addr_w-1:0]                    addr_in,
  input  logic [z80_bus_pkg::data_w-1:0]                    dout_in,
  output logic                                              wait_n,
  output logic [z80_bus_pkg::data_w-1:0]                    di,
  // wishbone classic master
  output logic                                              wb_cyc,
  output logic                                              wb_stb,
  output logic                                              wb_we,
  output logic [z80_bus_pkg::addr_w-1:0]                    wb_adr,
  output logic [z80_bus_pkg::data_w-1:0]                    wb_dat_o,
  output z80_bus_pkg::cycle_kind_t                          wb_tga,
  input  logic [z80_bus_pkg::data_w-1:0]                    wb_dat_i,
  input  logic                                              wb_ack,
  // instruction trace
  output logic                                              trace_valid,
  output logic [z80_bus_pkg::trace_bytes*z80_bus_pkg::data_w-1:0] trace_opcode,
  output logic [z80_bus_pkg::trace_cnt_w-1:0]               trace_count,
  output logic [z80_bus_pkg::addr_w-1:0]                    trace_addr
);

  z80_bus_if u_bus ();

  z80_strobe_gen u_strobe_gen (
    .cpu_bus  (cpu_bus),
    .arst_n   (arst_n),
    .mcycle   (mcycle),
    .tstate   (tstate),
    .write    (write),
    .iorq_req (iorq_req),
    .no_read  (no_read),
    .intcycle (intcycle),
    .m1_in    (m1_in),
    .addr_in  (addr_in),
    .dout_in  (dout_in),
    .bus      (u_bus.strobe)
  );

  wb_bus_bridge u_bridge (
    .cpu_bus  (cpu_bus),
    .arst_n   (arst_n),
    .bus      (u_bus.bridge),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_tga   (wb_tga),
    .wait_n   (wait_n),
    .di       (di)
  );

  opcode_tracer u_tracer (
    .cpu_bus      (cpu_bus),
    .arst_n       (arst_n),
    .bus          (u_bus.tracer),
    .trace_valid  (trace_valid),
    .trace_opcode (trace_opcode),
    .trace_count  (trace_count),
    .trace_addr   (trace_addr)
  );

endmodule

// ==== tb/z80_bus_checker.sv ====
/*
  z80 bus subsystem checker
  watches the wishbone and trace ports, matches every cycle and
  trace record against the queued expectations and counts errors
*/
`timescale 1ns/1ps

module z80_bus_checker (
  input logic                                                    cpu_bus,
  input logic                                                    arst_n,
  input logic                                                    wb_cyc,
  input logic                                                    wb_stb,
  input logic                                                    wb_we,
  input logic [z80_bus_pkg::addr_w-1:0]                          wb_adr,
  input logic [z80_bus_pkg::data_w-1:0]                          wb_dat_o,
  input z80_bus_pkg::cycle_kind_t                                wb_tga,
  input logic                                                    wb_ack,
  input logic                                                    wait_n,
  input logic [z80_bus_pkg::data_w-1:0]                          di,
  input logic                                                    trace_valid,
  input logic [z80_bus_pkg::trace_bytes*z80_bus_pkg::data_w-1:0] trace_opcode,
  input logic [z80_bus_pkg::trace_cnt_w-1:0]                     trace_count,
  input logic [z80_bus_pkg::addr_w-1:0]                          trace_addr
);

  z80_bus_pkg::cycle_kind_t exp_kind_q [$]; // one entry per expected wishbone cycle
  logic [15:0] exp_adr_q  [$];
  logic [7:0]  exp_dat_q  [$];             // write data, or the byte the read returns
  logic [31:0] exp_op_q   [$];             // one entry per expected trace record
  int          exp_cnt_q  [$];
  logic [15:0] exp_tadr_q [$];

  int n_tests  = 0;
  int n_failed = 0;
  int n_checks = 0;
  int n_errors = 0;
  int errs_at_start = 0;      // error count when the current test began
  logic        di_pending = 1'b0; // di is due one clock after a read ack
  logic [7:0]  di_exp;
  logic        in_cyc = 1'b0;
  logic [27:0] held;          // adr, we, tga and dat_o seen in the previous clock

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    begin
      n_checks++;
      if (got !== exp)
      begin
        $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        n_errors++;
      end
    end
  endtask

  task automatic expect_cycle(input z80_bus_pkg::cycle_kind_t kind, input logic [15:0] adr,
                              input logic [7:0] dat);
    begin
      exp_kind_q.push_back(kind);
      exp_adr_q.push_back(adr);
      exp_dat_q.push_back(dat);
    end
  endtask

  task automatic expect_trace(input logic [31:0] op, input int cnt, input logic [15:0] adr);
    begin
      exp_op_q.push_back(op);
      exp_cnt_q.push_back(cnt);
      exp_tadr_q.push_back(adr);
    end
  endtask

  // the cycle ends on this clock, so it must be the next one the core asked for
  task automatic match_cycle();
    z80_bus_pkg::cycle_kind_t kind;
    logic [15:0] adr;
    logic [7:0]  dat;
    logic        is_wr;
    begin
      if (exp_kind_q.size() == 0)
      begin
        $display("unexpected wishbone cycle to 0x%h with no access to match it", wb_adr);
        n_errors++;
      end
      else
      begin
        kind  = exp_kind_q.pop_front();
        adr   = exp_adr_q.pop_front();
        dat   = exp_dat_q.pop_front();
        is_wr = (kind == z80_bus_pkg::kind_mem_wr) || (kind == z80_bus_pkg::kind_io_wr);
        compare_value("wb_tga", 32'(wb_tga), 32'(kind));
        compare_value("wb_adr", 32'(wb_adr), 32'(adr));
        compare_value("wb_we", 32'(wb_we), 32'(is_wr));
        if (is_wr)
          compare_value("wb_dat_o", 32'(wb_dat_o), 32'(dat));
        else
        begin
          di_pending = 1'b1; // int ack returns the vector the same way
          di_exp     = dat;
        end
      end
    end
  endtask

  task automatic match_trace();
    begin
      if (exp_op_q.size() == 0)
      begin
        $display("unexpected trace record for 0x%h with no instruction to match it", trace_addr);
        n_errors++;
      end
      else
      begin
        compare_value("trace_opcode", trace_opcode, exp_op_q.pop_front());
        compare_value("trace_count", 32'(trace_count), 32'(exp_cnt_q.pop_front()));
        compare_value("trace_addr", 32'(trace_addr), 32'(exp_tadr_q.pop_front()));
      end
    end
  endtask

  // anything still queued here never showed up on the ports
  task automatic close_test(input string name);
    begin
      if (exp_kind_q.size() != 0)
      begin
        $display("%0d expected wishbone cycles never ran", exp_kind_q.size());
        n_errors += exp_kind_q.size();
        exp_kind_q.delete();
        exp_adr_q.delete();
        exp_dat_q.delete();
      end
      if (exp_op_q.size() != 0)
      begin
        $display("%0d expected trace records were never published", exp_op_q.size());
        n_errors += exp_op_q.size();
        exp_op_q.delete();
        exp_cnt_q.delete();
        exp_tadr_q.delete();
      end
      n_tests++;
      if (n_errors == errs_at_start)
        $display("test %0d, %s: pass", n_tests, name);
      else
      begin
        n_failed++;
        $display("test %0d, %s: fail with %0d errors", n_tests, name, n_errors - errs_at_start);
      end
      errs_at_start = n_errors;
    end
  endtask

  task automatic check_reset_state();
    begin
      compare_value("wb_cyc after reset", 32'(wb_cyc), 32'd0);
      compare_value("wb_stb after reset", 32'(wb_stb), 32'd0);
      compare_value("wb_we after reset", 32'(wb_we), 32'd0);
      compare_value("trace_valid after reset", 32'(trace_valid), 32'd0);
      compare_value("wait_n after reset", 32'(wait_n), 32'd1);
      close_test("reset state");
    end
  endtask

  // sampled on the rising edge, before any register in the DUT moves
  always @(posedge cpu_bus)
  begin
    if (arst_n)
    begin
      if (di_pending)
      begin
        compare_value("di after wait_n rose", 32'(di), 32'(di_exp));
        di_pending = 1'b0;
      end
      if (wb_cyc)
      begin
        compare_value("wait_n during a cycle", 32'(wait_n), 32'd0); // core must be held
        compare_value("wb_stb during a cycle", 32'(wb_stb), 32'd1);
        if (in_cyc && held !== {wb_adr, wb_we, wb_tga, wb_dat_o})
        begin
          $display("wishbone address, data, we or tga changed before ack at %0d ns", $time);
          n_errors++;
        end
        held   = {wb_adr, wb_we, wb_tga, wb_dat_o};
        in_cyc = !wb_ack;
        if (wb_ack)
          match_cycle();
      end
      else
        in_cyc = 1'b0;
      if (trace_valid)
        match_trace();
    end
  end

endmodule

// ==== tb/tb_z80_bus_sys.sv ====
/*
  testbench for the z80 bus subsystem
  plays the core from a table of accesses, answers wishbone cycles
  from a memory model with random wait states and feeds the checker
*/
`timescale 1ns/1ps

module tb_z80_bus_sys;

  typedef struct packed {
    logic                     m1;  // opcode fetch or interrupt ack that starts a new test
    z80_bus_pkg::cycle_kind_t kind;
    logic [15:0]              adr;
    logic [7:0]               dat; // write data that reads ignore
  } access_t;

  localparam int n_acc = 26;
  localparam int wd_limit = n_acc * 8 * 20 + 2000; // in ns with a margin for reset and idle gaps

  // each instruction is its fetch followed by its operand and data accesses
  access_t stim [n_acc] = '{
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0100, 8'h00},  // nop
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0101, 8'h00},  // ld a,n
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h0102, 8'h00},
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0103, 8'h00},  // ld (nn),a
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h0104, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h0105, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_wr, 16'h4000, 8'h3c},
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0106, 8'h00},  // in a,(n)
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h0107, 8'h00},
    '{1'b0, z80_bus_pkg::kind_io_rd,  16'h3c20, 8'h00},
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0108, 8'h00},  // out (n),a
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h0109, 8'h00},
    '{1'b0, z80_bus_pkg::kind_io_wr,  16'h3c21, 8'h3c},
    '{1'b1, z80_bus_pkg::kind_int_ack, 16'h010a, 8'h00}, // interrupt ack followed by the pc push
    '{1'b0, z80_bus_pkg::kind_mem_wr, 16'hfffe, 8'h01},
    '{1'b0, z80_bus_pkg::kind_mem_wr, 16'hfffd, 8'h0a},
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0038, 8'h00},  // ld ix,nn fills the record
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h0039, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h003a, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h003b, 8'h00},
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h003c, 8'h00},  // bit 0,(ix+d) reads five bytes
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h003d, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h003e, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h003f, 8'h00},
    '{1'b0, z80_bus_pkg::kind_mem_rd, 16'h1234, 8'h00},
    '{1'b1, z80_bus_pkg::kind_mem_rd, 16'h0040, 8'h00}   // nop publishes the last record
  };

  logic        cpu_bus = 1'b0;
  logic        arst_n;
  logic [6:0]  mcycle;
  logic [6:0]  tstate;
  logic        write;
  logic        iorq_req;
  logic        no_read;
  logic        intcycle;
  logic        m1_in;
  logic [15:0] addr_in;
  logic [7:0]  dout_in;
  logic        wait_n;
  logic [7:0]  di;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [7:0]  wb_dat_o;
  z80_bus_pkg::cycle_kind_t wb_tga;
  logic [7:0]  wb_dat_i = 8'h00;
  logic        wb_ack = 1'b0;
  logic        trace_valid;
  logic [31:0] trace_opcode;
  logic [2:0]  trace_count;
  logic [15:0] trace_addr;
  int          wait_left = -1;  // wait states left on the running cycle and -1 when idle
  logic [31:0] gather_op = '0;  // record of the instruction being played
  int          gather_cnt = 0;  // zero until the first fetch
  logic [15:0] gather_adr = '0;
  logic [15:0] grp_adr;

  z80_bus_sys u_dut (.*);

  z80_bus_checker u_chk (.*);

  always #10 cpu_bus = ~cpu_bus; // 20 ns bus clock with one t-state per rising edge

  // memory and io bytes mix both address bytes with 0x5a
  function automatic logic [7:0] model_byte(input logic [15:0] adr);
    return adr[15:8] ^ adr[7:0] ^ 8'h5a;
  endfunction

  // wishbone slave that acks after 0 to 3 wait states and drops ack the clock after
  always @(posedge cpu_bus)
  begin
    #2;
    if (wb_ack)
      wb_ack = 1'b0;
    else if (wb_cyc && wb_stb)
    begin
      if (wait_left < 0)
        wait_left = $urandom % 4; // a fresh delay for each new cycle
      if (wait_left == 0)
      begin
        wb_dat_i  = model_byte(wb_adr);
        wb_ack    = 1'b1;
        wait_left = -1;
      end
      else
        wait_left--;
    end
  end

  // queue the wishbone cycle and keep the trace record the access builds
  task automatic predict_access(input access_t a);
    logic [7:0] b;
    begin
      b = model_byte(a.adr);
      if (a.kind == z80_bus_pkg::kind_mem_wr || a.kind == z80_bus_pkg::kind_io_wr)
        u_chk.expect_cycle(a.kind, a.adr, a.dat);
      else
        u_chk.expect_cycle(a.kind, a.adr, b);
      if (a.m1 && a.kind == z80_bus_pkg::kind_mem_rd) // opcode fetch starts an instruction
      begin
        if (gather_cnt != 0)
          u_chk.expect_trace(gather_op, gather_cnt, gather_adr);
        gather_op  = {b, 24'h000000};
        gather_cnt = 1;
        gather_adr = a.adr;
      end
      else if (a.kind == z80_bus_pkg::kind_mem_rd && gather_cnt < z80_bus_pkg::trace_bytes)
      begin
        gather_op[(z80_bus_pkg::trace_bytes - 1 - gather_cnt) * 8 +: 8] = b; // first byte on top
        gather_cnt++;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    begin
      mcycle   = '0;
      tstate   = '0;
      write    = 1'b0;
      iorq_req = 1'b0;
      intcycle = 1'b0;
      m1_in    = 1'b0;
      repeat (n) @(posedge cpu_bus);
      #2;
    end
  endtask

  // steps through t1 to t3 (t4 for m1) and stays in t2 while wait_n is low
  task automatic play_access(input access_t a);
    int t;
    int last_t;
    begin
      mcycle   = a.m1 ? 7'b0000001 : 7'b0000010;
      m1_in    = a.m1;
      intcycle = (a.kind == z80_bus_pkg::kind_int_ack);
      write    = (a.kind == z80_bus_pkg::kind_mem_wr) || (a.kind == z80_bus_pkg::kind_io_wr);
      iorq_req = (a.kind == z80_bus_pkg::kind_io_rd) || (a.kind == z80_bus_pkg::kind_io_wr);
      no_read  = 1'b0;
      addr_in  = a.adr;
      dout_in  = a.dat;
      last_t   = a.m1 ? 4 : 3;
      t        = 1;
      while (t <= last_t)
      begin
        tstate    = '0;
        tstate[t] = 1'b1;
        @(posedge cpu_bus);
        #2;
        if (t != 2 || wait_n) // the core samples wait in t2 only
          t++;
      end
    end
  endtask

  initial
  begin
    void'($urandom(31782));
    arst_n   = 1'b0;
    mcycle   = '0;
    tstate   = '0;
    write    = 1'b0;
    iorq_req = 1'b0;
    no_read  = 1'b0;
    intcycle = 1'b0;
    m1_in    = 1'b0;
    addr_in  = '0;
    dout_in  = '0;
    repeat (16) @(posedge cpu_bus);
    #2;
    arst_n = 1'b1;
    idle_cycles(2);
    u_chk.check_reset_state();
    grp_adr = stim[0].adr;
    for (int i = 0; i < n_acc; i++)
    begin
      if (stim[i].m1 && i != 0) // the next fetch or ack closes the previous test
      begin
        idle_cycles(2);
        u_chk.close_test($sformatf("instruction at 0x%h", grp_adr));
        grp_adr = stim[i].adr;
      end
      predict_access(stim[i]);
      play_access(stim[i]);
    end
    idle_cycles(2);
    u_chk.close_test($sformatf("instruction at 0x%h", grp_adr));
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             u_chk.n_tests, u_chk.n_failed, u_chk.n_checks, u_chk.n_errors);
    if (u_chk.n_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // watchdog sized from the table since each access takes at most 8 t-states
  initial
  begin
    #(wd_limit);
    $display("timeout: the run did not finish within %0d ns", wd_limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
hw/z80_bus_pkg.sv
hw/z80_bus_if.sv
hw/z80_strobe_gen.sv
hw/wb_bus_bridge.sv
hw/opcode_tracer.sv
hw/z80_bus_sys.sv
tb/z80_bus_checker.sv
tb/tb_z80_bus_sys.sv

// ==== Makefile ====
SIM       := verilator
TOP       := tb_z80_bus_sys
FILELIST  := list.f
SIMFLAGS  := --binary --timing --top-module $(TOP)
LINTFLAGS := --lint-only --timing --top-module $(TOP)
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
